// File: w5500_pkg.sv
package w5500_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] buf_ptr_t;
    // Wide enough for the longest frame, a pull of 152 bits
    typedef logic [7:0] bit_cnt_t;

    localparam int payload_bits = 64;
    localparam int payload_bytes = payload_bits / 8;
    typedef logic [payload_bits-1:0] payload_t;

    localparam int cmd_frame_bits = 32;
    localparam int push_frame_bits = 24 + payload_bits;
    // Header, UDP info block of 8 bytes, then the payload
    localparam int rx_frame_bits = 24 + 64 + payload_bits;

    localparam logic [31:0] msg_id = 32'h7469_7277;

    localparam logic [47:0] local_mac = 48'hAAAF_FACC_E31C;
    localparam ip_addr_t local_ip = {8'd192, 8'd168, 8'd10, 8'd193};
    localparam ip_addr_t gateway_ip = {8'd192, 8'd168, 8'd10, 8'd1};
    localparam ip_addr_t subnet_mask = {8'd255, 8'd255, 8'd255, 8'd0};
    localparam udp_port_t local_port = 16'd2390;
    localparam ip_addr_t default_peer_ip = {8'd192, 8'd168, 8'd10, 8'd2};
    localparam udp_port_t default_peer_port = 16'd2390;

    localparam int rx_poll_cycles = 10;
    localparam int unsigned timeout_cycles_default = 4_800_000;
    localparam int init_steps = 32;

    typedef struct packed {
        logic [15:0] addr;
        byte_t ctrl;
        byte_t data;
    } w5500_cmd_t;

    typedef struct packed {
        ip_addr_t ip;
        udp_port_t port;
    } peer_t;

    typedef enum logic [1:0] {cmd, push, pull} frame_kind_t;

    typedef enum logic [3:0] {
        seq_init, seq_status, seq_idle, seq_rsr, seq_pull, seq_rd_lo, seq_rd_hi,
        seq_recv, seq_dest, seq_push, seq_wr_lo, seq_wr_hi, seq_send
    } seq_state_t;

    // Control phase: block select, read/write bit, variable length mode
    localparam byte_t write_reg = 8'h04;
    localparam byte_t write_s0 = 8'h0C;
    localparam byte_t read_s0 = 8'h08;
    localparam byte_t tx_buf_write = 8'h14;
    localparam byte_t rx_buf_read = 8'h18;

    // Common registers
    localparam logic [15:0] gar = 16'h0001;
    localparam logic [15:0] subr = 16'h0005;
    localparam logic [15:0] shar = 16'h0009;
    localparam logic [15:0] sipr = 16'h000F;
    localparam logic [15:0] phycfgr = 16'h002E;

    // Socket registers, multi-byte ones are big endian
    localparam logic [15:0] sn_mr = 16'h0000;
    localparam logic [15:0] sn_cr = 16'h0001;
    localparam logic [15:0] sn_sr = 16'h0003;
    localparam logic [15:0] sn_port = 16'h0004;
    localparam logic [15:0] sn_dipr = 16'h000C;
    localparam logic [15:0] sn_dport = 16'h0010;
    localparam logic [15:0] sn_rxbuf_size = 16'h001E;
    localparam logic [15:0] sn_txbuf_size = 16'h001F;
    localparam logic [15:0] sn_tx_wr = 16'h0024;
    localparam logic [15:0] sn_rx_rsr = 16'h0026;
    localparam logic [15:0] sn_rx_rd = 16'h0028;

    localparam byte_t phy_mode = 8'hD8;
    localparam byte_t sock_mode_udp = 8'h02;
    localparam byte_t buf_size_kb = 8'd16;
    localparam byte_t sock_udp_status = 8'h22;
    localparam byte_t cmd_open = 8'h01;
    localparam byte_t cmd_send = 8'h20;
    localparam byte_t cmd_recv = 8'h40;

endpackage

// File: spi_frame_engine.sv
`timescale 1ns/10ps

module spi_frame_engine (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  w5500_pkg::frame_kind_t kind,
    input  w5500_pkg::w5500_cmd_t  cmd,
    input  w5500_pkg::payload_t    push_data,
    input  logic                   miso,
    output logic                   sck,
    output logic                   mosi,
    output logic                   ssel_n,
    output logic                   done,
    output w5500_pkg::byte_t       read_byte,
    output logic                   sample,
    output logic                   sample_bit
);
    import w5500_pkg::*;

    logic active;
    frame_kind_t kind_q;
    bit_cnt_t bit_cnt;
    bit_cnt_t frame_len;
    logic [push_frame_bits-1:0] tx_shift;

    // Outgoing bits leave from the top, zeros fill in behind
    assign mosi = tx_shift[push_frame_bits-1];

    always_ff @(posedge clk) begin
        done <= 1'b0;
        sample <= 1'b0;
        if (reset) begin
            active <= 1'b0;
            sck <= 1'b0;
            ssel_n <= 1'b1;
            bit_cnt <= '0;
            tx_shift <= '0;
        end else if (start && !active) begin
            active <= 1'b1;
            ssel_n <= 1'b0;
            sck <= 1'b0;
            bit_cnt <= '0;
            kind_q <= kind;
            case (kind)
                push: begin
                    tx_shift <= {cmd.addr, cmd.ctrl, push_data};
                    frame_len <= bit_cnt_t'(push_frame_bits);
                end
                pull: begin
                    tx_shift <= {cmd.addr, cmd.ctrl, payload_t'(0)};
                    frame_len <= bit_cnt_t'(rx_frame_bits);
                end
                default: begin
                    tx_shift <= {cmd, {(push_frame_bits - cmd_frame_bits){1'b0}}};
                    frame_len <= bit_cnt_t'(cmd_frame_bits);
                end
            endcase
        end else if (active) begin
            if (bit_cnt == frame_len) begin
                active <= 1'b0;
                ssel_n <= 1'b1;
                done <= 1'b1;
            end else if (!sck) begin
                // Rising edge of sck, miso has been stable since the last fall
                sck <= 1'b1;
                sample <= (kind_q == pull);
                sample_bit <= miso;
                if (kind_q == w5500_pkg::cmd) begin
                    read_byte <= {read_byte[6:0], miso};
                end
            end else begin
                sck <= 1'b0;
                bit_cnt <= bit_cnt + 8'd1;
                tx_shift <= {tx_shift[push_frame_bits-2:0], 1'b0};
            end
        end
    end

endmodule

// File: w5500_init_rom.sv
`timescale 1ns/10ps

module w5500_init_rom (
    input  logic [4:0]            step,
    output w5500_pkg::w5500_cmd_t cmd
);
    import w5500_pkg::*;

    // Multi-byte values go out most significant byte first
    always_comb begin
        case (step) inside
            5'd0: cmd = {phycfgr, write_reg, phy_mode};
            [5'd1:5'd6]:
                cmd = {shar + 16'(step - 5'd1), write_reg, local_mac[8 * (7 - step) - 1 -: 8]};
            [5'd7:5'd10]:
                cmd = {sipr + 16'(step - 5'd7), write_reg, local_ip[8 * (11 - step) - 1 -: 8]};
            [5'd11:5'd14]:
                cmd = {gar + 16'(step - 5'd11), write_reg, gateway_ip[8 * (15 - step) - 1 -: 8]};
            [5'd15:5'd18]:
                cmd = {subr + 16'(step - 5'd15), write_reg, subnet_mask[8 * (19 - step) - 1 -: 8]};
            5'd19: cmd = {sn_mr, write_s0, sock_mode_udp};
            5'd20: cmd = {sn_rxbuf_size, write_s0, buf_size_kb};
            5'd21: cmd = {sn_txbuf_size, write_s0, buf_size_kb};
            5'd22: cmd = {sn_port, write_s0, local_port[15:8]};
            5'd23: cmd = {sn_port + 16'd1, write_s0, local_port[7:0]};
            5'd24: cmd = {sn_cr, write_s0, cmd_open};
            [5'd25:5'd28]:
                cmd = {sn_dipr + 16'(step - 5'd25), write_s0,
                       default_peer_ip[8 * (29 - step) - 1 -: 8]};
            5'd29: cmd = {sn_dport, write_s0, default_peer_port[15:8]};
            5'd30: cmd = {sn_dport + 16'd1, write_s0, default_peer_port[7:0]};
            // Last step reads back the socket status
            default: cmd = {sn_sr, read_s0, 8'h00};
        endcase
    end

endmodule

// File: udp_rx_decoder.sv
`timescale 1ns/10ps

module udp_rx_decoder (
    input  logic                clk,
    input  logic                reset,
    input  logic                sample,
    input  logic                sample_bit,
    input  logic                commit,
    output w5500_pkg::peer_t    peer,
    output w5500_pkg::payload_t rx_data
);
    import w5500_pkg::*;

    // Frame layout: SPI header, sender IP, sender port, length, payload
    logic [rx_frame_bits-1:0] frame;
    payload_t frame_payload;

    assign frame_payload = frame[payload_bits-1:0];

    always_ff @(posedge clk) begin
        if (sample) begin
            frame <= {frame[rx_frame_bits-2:0], sample_bit};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            peer <= '{ip: default_peer_ip, port: default_peer_port};
            rx_data <= '0;
        end else if (commit && frame_payload[payload_bits-1 -: 32] == msg_id) begin
            peer.ip <= frame[payload_bits + 63 -: 32];
            peer.port <= frame[payload_bits + 31 -: 16];
            rx_data <= frame_payload;
        end
    end

endmodule

// File: w5500_sequencer.sv
`timescale 1ns/10ps

module w5500_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   done,
    input  w5500_pkg::byte_t       read_byte,
    input  w5500_pkg::w5500_cmd_t  init_cmd,
    input  w5500_pkg::peer_t       peer,
    input  logic                   tx_request,
    input  w5500_pkg::payload_t    tx_data,
    output logic                   start,
    output w5500_pkg::frame_kind_t kind,
    output w5500_pkg::w5500_cmd_t  cmd,
    output w5500_pkg::payload_t    push_data,
    output logic [4:0]             step,
    output logic                   commit,
    output logic                   rx_accepted,
    output logic                   tx_taken
);
    import w5500_pkg::*;

    seq_state_t state;
    logic waiting;
    logic [3:0] poll_cnt;
    logic [2:0] dest_idx;
    logic good_len;
    logic size_ok;
    byte_t rx_size;
    buf_ptr_t rd_ptr;
    buf_ptr_t wr_ptr;
    buf_ptr_t rd_next;
    buf_ptr_t wr_next;

    assign size_ok = (read_byte == byte_t'(payload_bytes + 8));
    assign rd_next = rd_ptr + buf_ptr_t'(rx_size);
    assign wr_next = wr_ptr + buf_ptr_t'(payload_bytes);

    always_ff @(posedge clk) begin
        start <= 1'b0;
        commit <= 1'b0;
        rx_accepted <= 1'b0;
        tx_taken <= 1'b0;
        if (reset) begin
            state <= seq_init;
            waiting <= 1'b0;
            step <= '0;
            poll_cnt <= '0;
            dest_idx <= '0;
            good_len <= 1'b0;
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else if (waiting) begin
            if (done) begin
                waiting <= 1'b0;
                case (state)
                    seq_init: begin
                        step <= step + 5'd1;
                        if (step == 5'(init_steps - 1)) begin
                            state <= (read_byte == sock_udp_status) ? seq_idle : seq_status;
                        end
                    end
                    seq_status: begin
                        if (read_byte == sock_udp_status) begin
                            state <= seq_idle;
                        end
                    end
                    seq_rsr: begin
                        rx_size <= read_byte;
                        good_len <= size_ok;
                        if (read_byte == 8'd0) begin
                            state <= seq_idle;
                        end else begin
                            state <= size_ok ? seq_pull : seq_rd_lo;
                        end
                    end
                    seq_pull: begin
                        commit <= 1'b1;
                        state <= seq_rd_lo;
                    end
                    seq_rd_lo: state <= seq_rd_hi;
                    seq_rd_hi: state <= seq_recv;
                    seq_recv: begin
                        rd_ptr <= rd_next;
                        dest_idx <= '0;
                        state <= good_len ? seq_dest : seq_idle;
                    end
                    seq_dest: begin
                        if (dest_idx == 3'd5) begin
                            rx_accepted <= 1'b1;
                            state <= seq_idle;
                        end else begin
                            dest_idx <= dest_idx + 3'd1;
                        end
                    end
                    seq_push: state <= seq_wr_lo;
                    seq_wr_lo: state <= seq_wr_hi;
                    seq_wr_hi: state <= seq_send;
                    default: begin
                        wr_ptr <= wr_next;
                        tx_taken <= 1'b1;
                        state <= seq_idle;
                    end
                endcase
            end
        end else if (state == seq_idle) begin
            // tx_request is still high for the cycle after tx_taken
            if (tx_request && !tx_taken) begin
                state <= seq_push;
            end else if (poll_cnt == 4'(rx_poll_cycles)) begin
                poll_cnt <= '0;
                state <= seq_rsr;
            end else begin
                poll_cnt <= poll_cnt + 4'd1;
            end
        end else begin
            start <= 1'b1;
            waiting <= 1'b1;
            kind <= w5500_pkg::cmd;
            case (state)
                seq_init: cmd <= init_cmd;
                seq_status: cmd <= {sn_sr, read_s0, 8'h00};
                seq_rsr: cmd <= {sn_rx_rsr + 16'd1, read_s0, 8'h00};
                seq_pull: begin
                    kind <= pull;
                    cmd <= {rd_ptr, rx_buf_read, 8'h00};
                end
                seq_rd_lo: cmd <= {sn_rx_rd + 16'd1, write_s0, rd_next[7:0]};
                seq_rd_hi: cmd <= {sn_rx_rd, write_s0, rd_next[15:8]};
                seq_recv: cmd <= {sn_cr, write_s0, cmd_recv};
                // DIPR and DPORT are contiguous, six bytes in all
                seq_dest: cmd <= {sn_dipr + 16'(dest_idx), write_s0, peer[8 * (5 - dest_idx) +: 8]};
                seq_push: begin
                    kind <= push;
                    cmd <= {wr_ptr, tx_buf_write, 8'h00};
                    push_data <= tx_data;
                end
                seq_wr_lo: cmd <= {sn_tx_wr + 16'd1, write_s0, wr_next[7:0]};
                seq_wr_hi: cmd <= {sn_tx_wr, write_s0, wr_next[15:8]};
                default: cmd <= {sn_cr, write_s0, cmd_send};
            endcase
        end
    end

endmodule

// File: echo_control.sv
`timescale 1ns/10ps

module echo_control #(
    parameter int unsigned timeout_cycles = w5500_pkg::timeout_cycles_default
) (
    input  logic clk,
    input  logic reset,
    input  logic rx_accepted,
    input  logic tx_taken,
    output logic tx_request,
    output logic pkg_timeout
);

    logic [31:0] watchdog_cnt;

    // Counter holds at the limit until the next accepted datagram
    always_ff @(posedge clk) begin
        if (reset) begin
            watchdog_cnt <= '0;
            pkg_timeout <= 1'b0;
        end else if (rx_accepted) begin
            watchdog_cnt <= '0;
            pkg_timeout <= 1'b0;
        end else if (watchdog_cnt == timeout_cycles) begin
            pkg_timeout <= 1'b1;
        end else begin
            watchdog_cnt <= watchdog_cnt + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_request <= 1'b0;
        end else if (rx_accepted) begin
            tx_request <= 1'b1;
        end else if (tx_taken) begin
            tx_request <= 1'b0;
        end
    end

endmodule

// File: udp_echo_top.sv
`timescale 1ns/10ps

module udp_echo_top #(
    parameter int unsigned timeout_cycles = w5500_pkg::timeout_cycles_default
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                miso,
    output logic                sck,
    output logic                mosi,
    output logic                ssel_n,
    input  w5500_pkg::payload_t tx_data,
    output w5500_pkg::payload_t rx_data,
    output logic                pkg_timeout
);
    import w5500_pkg::*;

    logic start;
    logic done;
    logic sample;
    logic sample_bit;
    logic commit;
    logic rx_accepted;
    logic tx_request;
    logic tx_taken;
    logic [4:0] step;
    frame_kind_t kind;
    w5500_cmd_t frame_cmd;
    w5500_cmd_t init_cmd;
    payload_t push_data;
    byte_t read_byte;
    peer_t peer;

    spi_frame_engine engine (
        .clk, .reset, .start, .kind, .cmd(frame_cmd), .push_data, .miso,
        .sck, .mosi, .ssel_n, .done, .read_byte, .sample, .sample_bit
    );

    w5500_init_rom init_rom (.step, .cmd(init_cmd));

    udp_rx_decoder decoder (
        .clk, .reset, .sample, .sample_bit, .commit, .peer, .rx_data
    );

    w5500_sequencer sequencer (
        .clk, .reset, .done, .read_byte, .init_cmd, .peer, .tx_request, .tx_data,
        .start, .kind, .cmd(frame_cmd), .push_data, .step, .commit, .rx_accepted, .tx_taken
    );

    echo_control #(.timeout_cycles(timeout_cycles)) echo (
        .clk, .reset, .rx_accepted, .tx_taken, .tx_request, .pkg_timeout
    );

endmodule

// File: tb_w5500_model.sv
`timescale 1ns/10ps

module tb_w5500_model (
    input  logic sck,
    input  logic mosi,
    input  logic ssel_n,
    output logic miso
);
    import w5500_pkg::*;

    byte_t rx_mem [65536];
    byte_t tx_mem [65536];
    byte_t s0_regs [64];
    byte_t common_regs [64];
    byte_t sock_status;
    buf_ptr_t rx_wr;
    buf_ptr_t rsr;
    w5500_cmd_t cmd_log [$];
    int send_count;
    int recv_count;
    int nbits;
    logic [23:0] header_q;
    byte_t shreg;

    initial begin
        miso = 1'b0;
        sock_status = 8'h00;
        rx_wr = '0;
        rsr = '0;
        send_count = 0;
        recv_count = 0;
        nbits = 0;
        for (int i = 0; i < 64; i++) begin
            s0_regs[i] = 8'h00;
            common_regs[i] = 8'h00;
        end
    end

    function automatic byte_t read_at(logic [15:0] addr, byte_t ctrl, int k);
        if (ctrl == rx_buf_read) return rx_mem[addr + 16'(k)];
        if (ctrl != read_s0) return 8'h00;
        case (addr)
            sn_sr: return sock_status;
            sn_rx_rsr: return rsr[15:8];
            sn_rx_rsr + 16'd1: return rsr[7:0];
            default: return s0_regs[addr[5:0]];
        endcase
    endfunction

    task automatic complete_byte(int k, byte_t b);
        logic [15:0] addr;
        byte_t ctrl;
        addr = header_q[23:8];
        ctrl = header_q[7:0];
        if (k == 0 && ctrl != tx_buf_write && ctrl != rx_buf_read) begin
            cmd_log.push_back({addr, ctrl, (ctrl == read_s0) ? read_at(addr, ctrl, 0) : b});
        end
        if (ctrl == tx_buf_write) begin
            tx_mem[addr + 16'(k)] = b;
        end else if (ctrl == write_reg) begin
            common_regs[addr[5:0]] = b;
        end else if (ctrl == write_s0) begin
            s0_regs[addr[5:0]] = b;
            if (addr == sn_cr && b == cmd_open) sock_status = sock_udp_status;
            if (addr == sn_cr && b == cmd_send) send_count++;
            if (addr == sn_cr && b == cmd_recv) begin
                rsr = rx_wr - {s0_regs[sn_rx_rd[5:0]], s0_regs[sn_rx_rd[5:0] + 6'd1]};
                recv_count++;
            end
        end
    endtask

    // Datagram layout in the RX buffer: IP, port, length, then the data bytes
    task automatic inject(input peer_t p, input int n, input payload_t data);
        logic [63:0] info;
        info = {p.ip, p.port, 16'(n)};
        for (int i = 0; i < 8; i++) rx_mem[rx_wr + 16'(i)] = info[63 - 8 * i -: 8];
        for (int i = 0; i < n; i++) rx_mem[rx_wr + 16'(8 + i)] = data[63 - 8 * (i % 8) -: 8];
        rx_wr = rx_wr + 16'(8 + n);
        rsr = rsr + 16'(8 + n);
    endtask

    always @(negedge ssel_n) begin
        nbits = 0;
        miso = 1'b0;
    end

    always @(posedge sck) begin
        if (!ssel_n) begin
            shreg = {shreg[6:0], mosi};
            if (nbits < 24) header_q = {header_q[22:0], mosi};
            nbits++;
            if (nbits > 24 && (nbits - 24) % 8 == 0) complete_byte((nbits - 24) / 8 - 1, shreg);
        end
    end

    // Slave drives the next bit after each falling sck
    always @(negedge sck) begin
        byte_t rb;
        if (!ssel_n && nbits >= 24) begin
            rb = read_at(header_q[23:8], header_q[7:0], (nbits - 24) / 8);
            miso = rb[7 - (nbits - 24) % 8];
        end
    end

endmodule

// File: tb_udp_echo.sv
`timescale 1ns/10ps

module tb_udp_echo;
    import w5500_pkg::*;

    localparam int datagrams = 16;
    localparam int period_cycles = 3000;

    logic clk = 1'b0;
    logic reset;
    logic miso;
    logic sck;
    logic mosi;
    logic ssel_n;
    logic pkg_timeout;
    payload_t tx_data;
    payload_t rx_data;
    integer seed = 18;
    payload_t exp_rx;
    peer_t exp_peer;
    buf_ptr_t rd_exp;
    buf_ptr_t wr_exp;

    udp_echo_top #(.timeout_cycles(20000)) uut (.*);
    tb_w5500_model model (.sck, .mosi, .ssel_n, .miso);

    always #10 clk = ~clk;

    initial begin
        #(64'd200 * period_cycles * 20);
        $display("Watchdog expired after 200 datagram periods");
        end_in_failure();
    end

    task automatic end_in_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        end_in_failure();
    endtask

    task automatic check_payload(input payload_t got, input payload_t exp, input string what);
        if (got !== exp) mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_peer(input peer_t got, input peer_t exp, input string what);
        if (got !== exp) mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    function automatic int find_entry(byte_t ctrl, logic [15:0] addr, int from);
        for (int i = from; i < model.cmd_log.size(); i++) begin
            if (model.cmd_log[i].ctrl == ctrl && model.cmd_log[i].addr == addr) return i;
        end
        return -1;
    endfunction

    task automatic scan_log(input int from, output buf_ptr_t rd, output buf_ptr_t wr,
                            output peer_t dest, output int n_dest);
        w5500_cmd_t e;
        logic [47:0] d;
        n_dest = 0;
        d = '0;
        for (int i = from; i < model.cmd_log.size(); i++) begin
            e = model.cmd_log[i];
            if (e.ctrl == write_s0) begin
                if (e.addr == sn_rx_rd + 16'd1) rd[7:0] = e.data;
                if (e.addr == sn_rx_rd) rd[15:8] = e.data;
                if (e.addr == sn_tx_wr + 16'd1) wr[7:0] = e.data;
                if (e.addr == sn_tx_wr) wr[15:8] = e.data;
                if (e.addr >= sn_dipr && e.addr < sn_dipr + 16'd6) begin
                    d[8 * (5 - int'(e.addr - sn_dipr)) +: 8] = e.data;
                    n_dest++;
                end
            end
        end
        dest = d;
    endtask

    // kind 0 is a wrong length, 1 a wrong identifier, otherwise a good datagram
    task automatic run_datagram(input int kind);
        int from;
        int sends;
        int recvs;
        int n;
        int n_dest;
        int c;
        logic [31:0] r;
        peer_t p;
        payload_t data;
        payload_t echoed;
        buf_ptr_t rd;
        buf_ptr_t wr;
        peer_t dest;
        r = $random(seed);
        p.ip = $random(seed);
        p.port = r[31:16];
        data = {msg_id, 32'($random(seed))};
        if (kind == 1) data[63:32] = ~msg_id ^ {16'h0, r[15:0]};
        n = (kind == 0) ? int'(r[3:0]) : payload_bytes;
        if (kind == 0 && (n == 0 || n == payload_bytes)) n = 3;
        @(negedge clk);
        while (!ssel_n) @(negedge clk);
        from = model.cmd_log.size();
        sends = model.send_count;
        recvs = model.recv_count;
        tx_data = {32'($random(seed)), 32'($random(seed))};
        model.inject(p, n, data);
        rd_exp = rd_exp + 16'(8 + n);
        if (kind != 0) begin
            for (c = 0; c < period_cycles && model.send_count == sends; c++) @(negedge clk);
            if (model.send_count == sends) begin
                $display("No send command arrived after a datagram");
                end_in_failure();
            end
            if (kind != 1) begin
                exp_rx = data;
                exp_peer = p;
            end
            check_payload(rx_data, exp_rx, "rx_data");
            scan_log(from, rd, wr, dest, n_dest);
            if (n_dest != 6) mismatch($sformatf("%0d destination writes", n_dest));
            check_peer(dest, exp_peer, "destination");
            for (int i = 0; i < payload_bytes; i++) begin
                echoed[63 - 8 * i -: 8] = model.tx_mem[wr_exp + 16'(i)];
            end
            check_payload(echoed, tx_data, "TX buffer");
            wr_exp = wr_exp + 16'(payload_bytes);
            check_byte(wr[7:0], wr_exp[7:0], "TX_WR low");
            check_byte(wr[15:8], wr_exp[15:8], "TX_WR high");
        end else begin
            c = 0;
            while (c < period_cycles && (model.recv_count == recvs ||
                   find_entry(read_s0, sn_rx_rsr + 16'd1, find_entry(read_s0,
                   sn_rx_rsr + 16'd1, from) + 1) < 0)) begin
                @(negedge clk);
                c++;
            end
            if (c == period_cycles) begin
                $display("Sequencer did not return to polling after a short datagram");
                end_in_failure();
            end
            scan_log(from, rd, wr, dest, n_dest);
            if (n_dest != 0 || model.send_count != sends) mismatch("echo after a wrong length");
        end
        if (model.recv_count != recvs + 1) mismatch("receive command count");
        check_byte(rd[7:0], rd_exp[7:0], "RX_RD low");
        check_byte(rd[15:8], rd_exp[15:8], "RX_RD high");
    endtask

    initial begin
        int rsr_idx;
        int open_idx;
        int idx;
        int c;
        reset = 1'b1;
        tx_data = '0;
        exp_rx = '0;
        exp_peer = '{ip: default_peer_ip, port: default_peer_port};
        rd_exp = '0;
        wr_exp = '0;
        repeat (2) @(negedge clk);
        if (ssel_n !== 1'b1 || sck !== 1'b0 || mosi !== 1'b0 || pkg_timeout !== 1'b0) begin
            mismatch("SPI pins or timeout after reset");
        end
        check_payload(rx_data, '0, "rx_data after reset");
        reset = 1'b0;

        for (c = 0; c < period_cycles && find_entry(read_s0, sn_rx_rsr + 16'd1, 0) < 0; c++) begin
            @(negedge clk);
        end
        rsr_idx = find_entry(read_s0, sn_rx_rsr + 16'd1, 0);
        if (rsr_idx < 0) begin
            $display("Setup never reached the receive polling");
            end_in_failure();
        end
        open_idx = find_entry(write_s0, sn_cr, 0);
        if (open_idx < 0 || open_idx > rsr_idx) mismatch("open command missing before polling");
        check_byte(model.cmd_log[open_idx].data, cmd_open, "first socket command");
        for (int k = 0; k < 12; k++) begin
            if (k < 6) idx = find_entry(write_reg, shar + 16'(k), 0);
            else if (k < 10) idx = find_entry(write_reg, sipr + 16'(k - 6), 0);
            else idx = find_entry(write_s0, sn_port + 16'(k - 10), 0);
            if (idx < 0 || idx > open_idx) mismatch($sformatf("setup write %0d missing", k));
            if (k < 6) begin
                check_byte(model.cmd_log[idx].data, local_mac[47 - 8 * k -: 8], "MAC");
            end else if (k < 10) begin
                check_byte(model.cmd_log[idx].data, local_ip[31 - 8 * (k - 6) -: 8], "IP");
            end else begin
                check_byte(model.cmd_log[idx].data, local_port[15 - 8 * (k - 10) -: 8], "port");
            end
        end

        for (int i = 0; i < datagrams; i++) run_datagram($unsigned($random(seed)) % 4);

        for (c = 0; c < 25000 && !pkg_timeout; c++) @(negedge clk);
        if (!pkg_timeout) mismatch("pkg_timeout did not rise");
        run_datagram(2);
        if (pkg_timeout) mismatch("pkg_timeout still high after an accepted datagram");

        $display("Everything OK");
        $finish;
    end

endmodule

// File: sources.f
w5500_pkg.sv
spi_frame_engine.sv
w5500_init_rom.sv
udp_rx_decoder.sv
w5500_sequencer.sv
echo_control.sv
udp_echo_top.sv
tb_w5500_model.sv
tb_udp_echo.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_udp_echo -f sources.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
grep -q "Everything OK" sim.log || exit 1
exit 0
